// File: dense_weights.mem
// signed 8-bit weights, input-major, NB_NEURONS per input
00010100
11110100
00100011
11111001
11100111
00010010
00001001
00101000
00001110
00011110
11101010
11110001
00000111
11011111
00010000
00011001
11110110
00010110
11100100
00001100
00011111
11111011
00001011
11101101
11101111
00011011
00000110
00100001
00011000
11110010
11100010
00001000

// File: dense_bias.mem
// signed 8-bit bias per neuron
00000011
11111110
00000001
11111100

// File: tanh_fixed.mem
// tanh(k/16) for k = 0 to 64, Q16.16
00000000000000000000000000000000
00000000000000000000111111111011
00000000000000000001111111010110
00000000000000000010111101110010
00000000000000000011111010110011
00000000000000000100110101111110
00000000000000000101101110111101
00000000000000000110100101011110
00000000000000000111011001001101
00000000000000001000001010000011
00000000000000001000110111111010
00000000000000001001100010110000
00000000000000001010001010011001
00000000000000001010101111000010
00000000000000001011010000110011
00000000000000001011101111101101
00000000000000001100001011111000
00000000000000001100100101011101
00000000000000001100111100101110
00000000000000001101010001101101
00000000000000001101100100101001
00000000000000001101110101101100
00000000000000001110000100111111
00000000000000001110010010101101
00000000000000001110011110111000
00000000000000001110101001110001
00000000000000001110110011100001
00000000000000001110111100001100
00000000000000001111000011111110
00000000000000001111001010110101
00000000000000001111010000111101
00000000000000001111010110011000
00000000000000001111011011001011
00000000000000001111011111011010
00000000000000001111100011001011
00000000000000001111100110100000
00000000000000001111101001010110
00000000000000001111101100000010
00000000000000001111101110010111
00000000000000001111110000011010
00000000000000001111110010010011
00000000000000001111110011111010
00000000000000001111110101010100
00000000000000001111110110100101
00000000000000001111110111101000
00000000000000001111111000101001
00000000000000001111111001100000
00000000000000001111111010010001
00000000000000001111111010111100
00000000000000001111111011100010
00000000000000001111111100000011
00000000000000001111111100100000
00000000000000001111111100111010
00000000000000001111111101010001
00000000000000001111111101100101
00000000000000001111111101110111
00000000000000001111111110001001
00000000000000001111111110010101
00000000000000001111111110100010
00000000000000001111111110101101
00000000000000001111111110111000
00000000000000001111111110111111
00000000000000001111111111000111
00000000000000001111111111001110
00000000000000001111111111010100

// File: tb.f
+incdir+include
hdl/fixed_pkg.sv
hdl/layer_pkg.sv
hdl/dense_mac.sv
hdl/sum_fifo.sv
hdl/activation_unit.sv
hdl/rnn_dense_top.sv
tests/tb_rnn_dense.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rnn_dense -f tb.f -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "=== PASS ===" sim.log || exit 1

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// bias plus weighted features for one neuron, wraps at 32 bits
function automatic fixed_pkg::fixed_t ref_sum(
	input fixed_pkg::weight_t weights [layer_pkg::NB_INPUTS*layer_pkg::NB_NEURONS],
	input fixed_pkg::weight_t bias [layer_pkg::NB_NEURONS],
	input fixed_pkg::fixed_t  feats [layer_pkg::NB_INPUTS],
	input int                 neuron
);
	fixed_pkg::fixed_t acc;
	int                i;
	acc = fixed_pkg::fixed_t'(bias[neuron]) * 65536;
	for (i = 0; i < layer_pkg::NB_INPUTS; i++) begin
		acc = acc + fixed_pkg::fixed_t'(weights[i*layer_pkg::NB_NEURONS + neuron]) * feats[i];
	end
	return acc;
endfunction

// scale, interpolated tanh with saturation, optional sigmoid
function automatic fixed_pkg::fixed_t ref_activate(
	input fixed_pkg::fixed_t sum,
	input layer_pkg::act_e   act,
	input fixed_pkg::fixed_t tanh_tab [fixed_pkg::TANH_DEPTH]
);
	fixed_pkg::fixed_t    scaled;
	fixed_pkg::act_word_u mag;
	fixed_pkg::fixed_t    t;
	longint               blend;
	int                   k;
	int                   f;
	scaled  = (act == layer_pkg::ACT_SIGMOID) ? (sum >>> 9) : (sum >>> 8);
	mag.raw = (scaled < 0) ? -scaled : scaled;
	k       = int'(mag.fields.idx);
	f       = int'(mag.fields.frac);
	blend   = longint'(tanh_tab[k]) * (4096 - f) + longint'(tanh_tab[k+1]) * f;
	t       = fixed_pkg::fixed_t'(blend >>> 12);
	if (mag.fields.sat_bits != 0) begin
		t = fixed_pkg::ONE;
	end
	if (scaled < 0) begin
		t = -t;
	end
	if (act == layer_pkg::ACT_SIGMOID) begin
		t = (t >>> 1) + fixed_pkg::HALF;
	end
	return t;
endfunction

`endif

// File: tests/tb_rnn_dense.sv
module tb_rnn_dense;

	timeunit 1ns;
	timeprecision 1ps;

	import fixed_pkg::*;
	import layer_pkg::*;

	`include "tb_ref_model.svh"

	localparam int NUM_ROWS   = 7;
	localparam int WAIT_LIMIT = 400;

	logic          clk;
	logic          rst;
	feature_beat_t feat_i;
	logic          feat_valid_i;
	logic          feat_ready_o;
	gain_beat_t    gain_o;
	logic          gain_valid_o;
	logic          gain_ready_i;

	weight_t weights  [NB_INPUTS*NB_NEURONS];
	weight_t biases   [NB_NEURONS];
	fixed_t  tanh_tab [TANH_DEPTH];

	// stimulus table with one row per frame
	string  row_name [NUM_ROWS];
	act_e   row_act  [NUM_ROWS];
	fixed_t row_feat [NUM_ROWS][NB_INPUTS];
	logic   row_bp   [NUM_ROWS];
	logic   row_rst  [NUM_ROWS];

	logic [31:0] rng_state;

	rnn_dense_top i_rnn_dense_top (
		.clk          (clk),
		.rst          (rst),
		.feat_i       (feat_i),
		.feat_valid_i (feat_valid_i),
		.feat_ready_o (feat_ready_o),
		.gain_o       (gain_o),
		.gain_valid_o (gain_valid_o),
		.gain_ready_i (gain_ready_i)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic random_bit(output logic b);
		rng_state = xorshift32(rng_state);
		b = rng_state[7];
	endtask

	// inputs change 2 ns after the rising edge
	task automatic step;
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		$display("=== FAIL ===");
		$fatal(1, "wait limit reached");
	endtask

	// features listed first to last
	task automatic set_row(input int r, input string name, input act_e act,
			input logic [NB_INPUTS-1:0][31:0] f, input logic bp, input logic rm);
		int i;
		row_name[r] = name;
		row_act[r]  = act;
		row_bp[r]   = bp;
		row_rst[r]  = rm;
		for (i = 0; i < NB_INPUTS; i++) begin
			row_feat[r][i] = f[NB_INPUTS-1-i];
		end
	endtask

	task automatic send_features(input int r);
		int i;
		int waited;
		for (i = 0; i < NB_INPUTS; i++) begin
			feat_i.data  = row_feat[r][i];
			feat_i.act   = row_act[r];
			feat_i.last  = (i == NB_INPUTS - 1);
			feat_valid_i = 1'b1;
			waited = 0;
			while (!feat_ready_o) begin
				step;
				waited++;
				if (waited > WAIT_LIMIT) report_timeout("feature input never became ready");
			end
			step;
		end
		feat_valid_i = 1'b0;
		feat_i.last  = 1'b0;
	endtask

	task automatic collect_gains(input int r, input fixed_t expected [NB_NEURONS]);
		int    n;
		int    waited;
		logic  rdy;
		string tag;
		n      = 0;
		waited = 0;
		while (n < NB_NEURONS) begin
			if (row_bp[r]) random_bit(rdy);
			else rdy = 1'b1;
			gain_ready_i = rdy;
			if (gain_valid_o && rdy) begin
				tag = $sformatf("%s gain %0d", row_name[r], n);
				check_value(tag, expected[n], gain_o.value);
				check_value({tag, " last"}, 32'(n == NB_NEURONS - 1), 32'(gain_o.last));
				if (row_act[r] == ACT_SIGMOID) begin
					check_value({tag, " range"}, 1,
						32'(($signed(gain_o.value) >= 0) && ($signed(gain_o.value) <= ONE)));
				end
				n++;
			end
			step;
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("gains missing at the output");
		end
		gain_ready_i = 1'b0;
	endtask

	task automatic apply_row(input int r);
		fixed_t expected [NB_NEURONS];
		fixed_t feats    [NB_INPUTS];
		int     i;
		int     waited;
		for (i = 0; i < NB_INPUTS; i++) feats[i] = row_feat[r][i];
		for (i = 0; i < NB_NEURONS; i++) begin
			expected[i] = ref_activate(ref_sum(weights, biases, feats, i), row_act[r], tanh_tab);
		end
		// reset while the frame is still being computed and gains are held
		if (row_rst[r]) begin
			send_features(r);
			waited = 0;
			while (!gain_valid_o) begin
				step;
				waited++;
				if (waited > WAIT_LIMIT) report_timeout("no gain appeared before the reset");
			end
			rst = 1'b1;
			repeat (4) step;
			rst = 1'b0;
			check_value({row_name[r], " valid after reset"}, 0, 32'(gain_valid_o));
			check_value({row_name[r], " ready after reset"}, 1, 32'(feat_ready_o));
		end
		fork
			send_features(r);
			collect_gains(r, expected);
		join
	endtask

	initial begin
		rst          = 1'b1;
		feat_i       = '0;
		feat_valid_i = 1'b0;
		gain_ready_i = 1'b0;
		rng_state    = 32'd99;
		$readmemb("dense_weights.mem", weights);
		$readmemb("dense_bias.mem", biases);
		$readmemb("tanh_fixed.mem", tanh_tab);

		set_row(0, "tanh_moderate", ACT_TANH,
			{32'h0001_0000, 32'h0000_8000, 32'hffff_4000, 32'h0002_0000,
			 32'hfffe_c000, 32'h0000_4000, 32'h0001_8000, 32'hffff_8000}, 1'b0, 1'b0);
		set_row(1, "sigmoid_moderate", ACT_SIGMOID,
			{32'h0003_0000, 32'hfffe_0000, 32'h0000_c000, 32'h0001_0000,
			 32'hfffd_0000, 32'h0002_0000, 32'hffff_8000, 32'h0000_4000}, 1'b0, 1'b0);
		set_row(2, "tanh_saturate_pos", ACT_TANH, {NB_INPUTS{32'h0064_0000}}, 1'b0, 1'b0);
		set_row(3, "sigmoid_saturate_neg", ACT_SIGMOID, {NB_INPUTS{32'hff9c_0000}}, 1'b0, 1'b0);
		set_row(4, "tanh_backpressure", ACT_TANH,
			{32'hffff_0000, 32'h0002_0000, 32'h0001_8000, 32'hffff_4000,
			 32'h0000_8000, 32'h0003_0000, 32'hfffe_c000, 32'h0001_0000}, 1'b1, 1'b0);
		set_row(5, "sigmoid_backpressure", ACT_SIGMOID,
			{32'h0064_0000, 32'hff9c_0000, 32'h0001_0000, 32'h0000_8000,
			 32'hffff_8000, 32'h0002_0000, 32'hfffe_0000, 32'h0000_c000}, 1'b1, 1'b0);
		set_row(6, "tanh_after_reset", ACT_TANH,
			{32'h0000_4000, 32'hffff_0000, 32'h0002_0000, 32'h0001_0000,
			 32'hffff_8000, 32'h0001_8000, 32'h0000_c000, 32'hfffe_0000}, 1'b0, 1'b1);

		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: hdl/rnn_dense_top.sv
module rnn_dense_top (
	input  logic                     clk,
	input  logic                     rst,
	input  layer_pkg::feature_beat_t feat_i,
	input  logic                     feat_valid_i,
	output logic                     feat_ready_o,
	output layer_pkg::gain_beat_t    gain_o,
	output logic                     gain_valid_o,
	input  logic                     gain_ready_i
);

	import layer_pkg::*;

	sum_beat_t mac_sum;
	logic      mac_valid;
	logic      mac_ready;

	sum_beat_t act_sum;
	logic      act_valid;
	logic      act_ready;

	dense_mac i_dense_mac (
		.clk          (clk),
		.rst          (rst),
		.feat_i       (feat_i),
		.feat_valid_i (feat_valid_i),
		.feat_ready_o (feat_ready_o),
		.sum_o        (mac_sum),
		.sum_valid_o  (mac_valid),
		.sum_ready_i  (mac_ready)
	);

	sum_fifo #(
		.FIFO_DEPTH (SUM_FIFO_DEPTH)
	) i_sum_fifo (
		.clk          (clk),
		.rst          (rst),
		.push_i       (mac_sum),
		.push_valid_i (mac_valid),
		.push_ready_o (mac_ready),
		.pop_o        (act_sum),
		.pop_valid_o  (act_valid),
		.pop_ready_i  (act_ready)
	);

	activation_unit i_activation_unit (
		.clk          (clk),
		.rst          (rst),
		.sum_i        (act_sum),
		.sum_valid_i  (act_valid),
		.sum_ready_o  (act_ready),
		.gain_o       (gain_o),
		.gain_valid_o (gain_valid_o),
		.gain_ready_i (gain_ready_i)
	);

endmodule

// File: hdl/activation_unit.sv
module activation_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  layer_pkg::sum_beat_t  sum_i,
	input  logic                  sum_valid_i,
	output logic                  sum_ready_o,
	output layer_pkg::gain_beat_t gain_o,
	output logic                  gain_valid_o,
	input  logic                  gain_ready_i
);

	import fixed_pkg::*;
	import layer_pkg::*;

	fixed_t tanh_rom [TANH_DEPTH];

	initial begin
		$readmemb("tanh_fixed.mem", tanh_rom);
	end

	logic advance;

	fixed_t    scaled;
	act_word_u mag_in;

	logic      s1_valid;
	act_word_u s1_mag;
	logic      s1_neg;
	act_e      s1_act;
	logic      s1_last;

	logic [TANH_IDX_W:0]    idx_hi;
	logic [TANH_STEP_W:0]   w_lo;
	logic [2*FIXED_W-1:0]   mix;
	fixed_t                 interp;
	fixed_t                 tanh_val;
	fixed_t                 act_val;

	// a held output freezes both stages
	assign advance     = !(gain_valid_o && !gain_ready_i);
	assign sum_ready_o = advance;

	// stage 1 scale and magnitude, sigmoid takes x/2
	always_comb begin
		if (sum_i.act == ACT_SIGMOID) begin
			scaled = sum_i.sum >>> (WEIGHT_SHIFT + 1);
		end else begin
			scaled = sum_i.sum >>> WEIGHT_SHIFT;
		end
		mag_in.raw = scaled[FIXED_W-1] ? -scaled : scaled;
	end

	// stage 2 table interpolation
	always_comb begin
		idx_hi = {1'b0, s1_mag.fields.idx} + 1'b1;
		w_lo   = {1'b1, {TANH_STEP_W{1'b0}}} - {1'b0, s1_mag.fields.frac};
		mix    = 64'(tanh_rom[s1_mag.fields.idx]) * 64'(w_lo)
		       + 64'(tanh_rom[idx_hi]) * 64'(s1_mag.fields.frac);
		interp = mix[FIXED_W+TANH_STEP_W-1:TANH_STEP_W];

		if (s1_mag.fields.sat_bits != '0) begin
			tanh_val = s1_neg ? MINUS_ONE : ONE;
		end else begin
			tanh_val = s1_neg ? -interp : interp;
		end

		// sigmoid(x) = tanh(x/2)/2 + 1/2
		if (s1_act == ACT_SIGMOID) begin
			act_val = (tanh_val >>> 1) + HALF;
		end else begin
			act_val = tanh_val;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid     <= 1'b0;
			gain_valid_o <= 1'b0;
		end else if (advance) begin
			s1_valid     <= sum_valid_i;
			gain_valid_o <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			s1_mag       <= mag_in;
			s1_neg       <= scaled[FIXED_W-1];
			s1_act       <= sum_i.act;
			s1_last      <= sum_i.last;
			gain_o.value <= act_val;
			gain_o.last  <= s1_last;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(gain_valid_o && !gain_ready_i) |=> (gain_valid_o && $stable(gain_o)));

endmodule

// File: hdl/sum_fifo.sv
module sum_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  layer_pkg::sum_beat_t push_i,
	input  logic                 push_valid_i,
	output logic                 push_ready_o,
	output layer_pkg::sum_beat_t pop_o,
	output logic                 pop_valid_o,
	input  logic                 pop_ready_i
);

	import layer_pkg::*;

	sum_beat_t mem [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(FIFO_DEPTH+1)-1:0] count;
	logic                            push_fire;
	logic                            pop_fire;

	assign push_ready_o = (int'(count) != FIFO_DEPTH);
	assign pop_valid_o  = (count != '0);
	assign pop_o        = mem[rd_ptr];
	assign push_fire    = push_valid_i && push_ready_o;
	assign pop_fire     = pop_valid_o && pop_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire) begin
				wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_fire) begin
				rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			if (push_fire && !pop_fire) begin
				count <= count + 1'b1;
			end else if (pop_fire && !push_fire) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push_fire) begin
			mem[wr_ptr] <= push_i;
		end
	end

	// occupancy stays in range, an empty FIFO never underflows
	assert property (@(posedge clk) disable iff (rst)
		(int'(count) <= FIFO_DEPTH) && (($past(count) != '0) || (int'(count) <= 1)));

endmodule

// File: hdl/dense_mac.sv
module dense_mac (
	input  logic                  clk,
	input  logic                  rst,
	input  layer_pkg::feature_beat_t feat_i,
	input  logic                  feat_valid_i,
	output logic                  feat_ready_o,
	output layer_pkg::sum_beat_t  sum_o,
	output logic                  sum_valid_o,
	input  logic                  sum_ready_i
);

	import fixed_pkg::*;
	import layer_pkg::*;

	typedef enum logic [1:0] {
		S_CAPTURE,
		S_BIAS,
		S_MAC,
		S_EMIT
	} state_e;

	state_e state;

	weight_t weight_rom [NB_INPUTS*NB_NEURONS];
	weight_t bias_rom   [NB_NEURONS];
	fixed_t  feat_mem   [NB_INPUTS];

	logic [IN_IDX_W-1:0]     in_cnt;
	logic [NEURON_IDX_W-1:0] neuron_cnt;
	logic [W_ADDR_W-1:0]     w_addr;
	fixed_t                  acc_q;
	act_e                    act_q;
	logic                    feat_fire;

	initial begin
		$readmemb("dense_weights.mem", weight_rom);
		$readmemb("dense_bias.mem", bias_rom);
	end

	assign feat_ready_o = (state == S_CAPTURE);
	assign feat_fire    = feat_valid_i && feat_ready_o;

	// input-major layout, stride NB_NEURONS
	assign w_addr = W_ADDR_W'(in_cnt) * W_ADDR_W'(NB_NEURONS) + W_ADDR_W'(neuron_cnt);

	assign sum_valid_o = (state == S_EMIT);
	assign sum_o.sum   = acc_q;
	assign sum_o.act   = act_q;
	assign sum_o.last  = (neuron_cnt == NEURON_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_CAPTURE;
			in_cnt     <= '0;
			neuron_cnt <= '0;
		end else begin
			case (state)
				S_CAPTURE: begin
					if (feat_fire) begin
						if (feat_i.last) begin
							state      <= S_BIAS;
							in_cnt     <= '0;
							neuron_cnt <= '0;
						end else begin
							in_cnt <= in_cnt + 1'b1;
						end
					end
				end
				S_BIAS: begin
					state <= S_MAC;
				end
				S_MAC: begin
					if (in_cnt == IN_LAST) begin
						in_cnt <= '0;
						state  <= S_EMIT;
					end else begin
						in_cnt <= in_cnt + 1'b1;
					end
				end
				S_EMIT: begin
					if (sum_ready_i) begin
						if (neuron_cnt == NEURON_LAST) begin
							state <= S_CAPTURE;
						end else begin
							neuron_cnt <= neuron_cnt + 1'b1;
							state      <= S_BIAS;
						end
					end
				end
				default: state <= S_CAPTURE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (feat_fire) begin
			feat_mem[in_cnt] <= feat_i.data;
			if (in_cnt == '0) begin
				act_q <= feat_i.act;
			end
		end
		// bias sits at the Q16.16 integer point
		if (state == S_BIAS) begin
			acc_q <= fixed_t'(bias_rom[neuron_cnt]) <<< FRAC_W;
		end else if (state == S_MAC) begin
			acc_q <= acc_q + fixed_t'(weight_rom[w_addr]) * feat_mem[in_cnt];
		end
	end

	// last must close the frame exactly on the final feature
	assert property (@(posedge clk) disable iff (rst)
		feat_fire |-> (feat_i.last == (in_cnt == IN_LAST)));

endmodule

// File: hdl/layer_pkg.sv
package layer_pkg;

	import fixed_pkg::*;

	localparam int NB_INPUTS  = 8;
	localparam int NB_NEURONS = 4;

	localparam int IN_IDX_W     = $clog2(NB_INPUTS);
	localparam int NEURON_IDX_W = $clog2(NB_NEURONS);
	localparam int W_ADDR_W     = $clog2(NB_INPUTS * NB_NEURONS);

	localparam logic [IN_IDX_W-1:0]     IN_LAST     = IN_IDX_W'(NB_INPUTS - 1);
	localparam logic [NEURON_IDX_W-1:0] NEURON_LAST = NEURON_IDX_W'(NB_NEURONS - 1);

	localparam int SUM_FIFO_DEPTH = 4;

	typedef enum logic {
		ACT_TANH,
		ACT_SIGMOID
	} act_e;

	// act only matters on the first beat of a frame
	typedef struct packed {
		fixed_t data;
		act_e   act;
		logic   last;
	} feature_beat_t;

	typedef struct packed {
		fixed_t sum;
		act_e   act;
		logic   last;
	} sum_beat_t;

	typedef struct packed {
		fixed_t value;
		logic   last;
	} gain_beat_t;

endpackage

// File: hdl/fixed_pkg.sv
package fixed_pkg;

	// Q16.16 word layout
	localparam int FIXED_W  = 32;
	localparam int FRAC_W   = 16;
	localparam int WEIGHT_W = 8;

	typedef logic signed [FIXED_W-1:0]  fixed_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;

	localparam fixed_t ONE       = 32'sh0001_0000;
	localparam fixed_t HALF      = 32'sh0000_8000;
	localparam fixed_t MINUS_ONE = 32'shffff_0000;

	// weights carry an implicit scale of 1/256
	localparam int WEIGHT_SHIFT = 8;

	// tanh table covers 0 to 4 in steps of 1/16
	localparam int TANH_IDX_W  = 6;
	localparam int TANH_STEP_W = 12;
	localparam int TANH_DEPTH  = 65;
	localparam int SAT_W       = FIXED_W - TANH_IDX_W - TANH_STEP_W;

	typedef struct packed {
		logic [SAT_W-1:0]       sat_bits;
		logic [TANH_IDX_W-1:0]  idx;
		logic [TANH_STEP_W-1:0] frac;
	} act_fields_t;

	// magnitude seen as a plain word or as table lookup fields
	typedef union packed {
		fixed_t      raw;
		act_fields_t fields;
	} act_word_u;

endpackage
